/* common/pool_defines.svh */
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// Channels carried by one atom
`define BURST_LEN 16

// Signed activation width
`define DATA_W 16

// Lane sum width, 4 guard bits hold up to 16 atoms
`define ACC_W (`DATA_W + 4)

`define WIN_LOG2_W 3   // Window size field, legal 0..4
`define SIDE_W 8       // Windows per run

`define BURST_CNT_W 4  // Word index inside an atom
`define WIN_CNT_W 5    // Atom index inside a window, also holds 2^4

`endif

/* common/pool_pkg.sv */
`include "pool_defines.svh"

package pool_pkg;

	// One activation and one widened lane sum
	typedef logic signed [`DATA_W-1:0] data_t;
	typedef logic signed [`ACC_W-1:0] acc_t;

	// Lane 0 holds the first word of the burst
	typedef data_t atom_t [`BURST_LEN];
	typedef acc_t sum_atom_t [`BURST_LEN];

	// Code 1 was convolution, left unused
	typedef enum logic [1:0] {
		OP_NONE    = 2'd0,
		OP_MAXPOOL = 2'd2,
		OP_AVEPOOL = 2'd3
	} op_e;

	// Run controller states
	typedef enum logic [1:0] {
		ST_INIT,
		ST_IDLE,
		ST_BUSY,
		ST_FINISH
	} state_e;

endpackage

/* verilog/pool_ctrl.sv */
`include "pool_defines.svh"

module pool_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_engine_valid,
	input  pool_pkg::op_e          i_op_type,
	input  logic [`WIN_LOG2_W-1:0] i_window_log2,
	input  logic [`SIDE_W-1:0]     i_o_side,
	input  logic                   i_atom_valid,
	input  logic                   i_wb_done,
	output logic                   o_dma_rd_en,
	output logic                   o_max_en,
	output logic                   o_ave_en,
	output logic                   o_win_first,
	output logic                   o_win_last,
	output logic                   o_engine_ready
);

	pool_pkg::state_e      state;
	pool_pkg::state_e      state_nxt;
	logic [`WIN_CNT_W-1:0] atom_cnt;   // Atoms seen in current window
	logic [`WIN_CNT_W-1:0] win_size;   // 2^i_window_log2
	logic [`SIDE_W-1:0]    win_cnt;    // Windows written back so far
	logic                  is_pool;
	logic                  busy;
	logic                  run_done;

	assign is_pool = (i_op_type == pool_pkg::OP_MAXPOOL) ||
	                 (i_op_type == pool_pkg::OP_AVEPOOL);
	assign busy    = (state == pool_pkg::ST_BUSY);

	// Window length in atoms, at most 16
	assign win_size = `WIN_CNT_W'(1) << i_window_log2;

	// Last write-back of the run
	assign run_done = busy && i_wb_done && ((win_cnt + 1'b1) == i_o_side);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pool_pkg::ST_INIT;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state; // Hold by default
		case (state)
			pool_pkg::ST_INIT: begin
				if (i_engine_valid)
					state_nxt = pool_pkg::ST_IDLE;
			end
			pool_pkg::ST_IDLE: begin
				if (i_engine_valid && is_pool)
					state_nxt = pool_pkg::ST_BUSY;
			end
			pool_pkg::ST_BUSY: begin
				if (run_done)
					state_nxt = pool_pkg::ST_FINISH;
			end
			pool_pkg::ST_FINISH: begin
				if (!i_engine_valid) // Host drops request, back to idle
					state_nxt = pool_pkg::ST_IDLE;
			end
			default: state_nxt = pool_pkg::ST_INIT;
		endcase
	end

	// Counters run in BUSY, cleared while idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atom_cnt <= '0;
			win_cnt  <= '0;
		end else if (state == pool_pkg::ST_IDLE) begin
			atom_cnt <= '0;
			win_cnt  <= '0;
		end else if (busy) begin
			if (i_atom_valid) begin
				if (o_win_last)
					atom_cnt <= '0; // Window closed
				else
					atom_cnt <= atom_cnt + 1'b1;
			end
			if (i_wb_done)
				win_cnt <= win_cnt + 1'b1;
		end
	end

	// Window position of the atom now on the bus
	assign o_win_first = (atom_cnt == '0);
	assign o_win_last  = (atom_cnt == (win_size - 1'b1));

	// Only one reducer sees the atom strobe
	assign o_max_en = busy && i_atom_valid && (i_op_type == pool_pkg::OP_MAXPOOL);
	assign o_ave_en = busy && i_atom_valid && (i_op_type == pool_pkg::OP_AVEPOOL);

	assign o_dma_rd_en    = busy;
	assign o_engine_ready = (state == pool_pkg::ST_FINISH);

endmodule

/* verilog/atom_deserializer.sv */
`include "pool_defines.svh"

module atom_deserializer (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_rd_en,
	input  logic            i_rd_we,
	input  pool_pkg::data_t i_rd_data,
	output logic            o_atom_valid,
	output pool_pkg::atom_t o_atom
);

	pool_pkg::atom_t         lane_buf;   // Shift buffer, newest word at top lane
	logic [`BURST_CNT_W-1:0] burst_cnt;  // Words gathered so far
	logic                    word_in;

	assign word_in = i_rd_en && i_rd_we;

	// Shift down so the first word ends in lane 0
	always_ff @(posedge clk) begin
		if (word_in) begin
			for (int k = 0; k < `BURST_LEN - 1; k++)
				lane_buf[k] <= lane_buf[k + 1];
			lane_buf[`BURST_LEN - 1] <= i_rd_data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			burst_cnt    <= '0;
			o_atom_valid <= 1'b0;
		end else if (!i_rd_en) begin
			burst_cnt    <= '0; // Next run starts on an atom boundary
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= word_in && (burst_cnt == (`BURST_LEN - 1));
			if (word_in)
				burst_cnt <= burst_cnt + 1'b1; // Wraps after the last lane
		end
	end

	assign o_atom = lane_buf;

endmodule

/* pool_lanes/max_pool_lanes.sv */
`include "pool_defines.svh"

module max_pool_lanes (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_en,
	input  logic            i_first,
	input  logic            i_last,
	input  pool_pkg::atom_t i_atom,
	output logic            o_result_valid,
	output pool_pkg::atom_t o_result
);

	pool_pkg::atom_t max_q;    // Running maximum per lane
	pool_pkg::atom_t max_nxt;

	// Each lane compared on its own, signed
	always_comb begin
		for (int k = 0; k < `BURST_LEN; k++) begin
			if (i_first || (i_atom[k] > max_q[k]))
				max_nxt[k] = i_atom[k]; // New window or larger value
			else
				max_nxt[k] = max_q[k];
		end
	end

	always_ff @(posedge clk) begin
		if (i_en)
			max_q <= max_nxt;
	end

	// Pulse once the last atom is folded in
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_en && i_last;
	end

	// Holds the window maximum until the next window starts
	assign o_result = max_q;

endmodule

/* pool_lanes/ave_pool_lanes.sv */
`include "pool_defines.svh"

module ave_pool_lanes (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_en,
	input  logic                   i_first,
	input  logic                   i_last,
	input  logic [`WIN_LOG2_W-1:0] i_window_log2,
	input  pool_pkg::atom_t        i_atom,
	output logic                   o_result_valid,
	output pool_pkg::atom_t        o_result
);

	pool_pkg::sum_atom_t sum_q;    // Running lane sums, sign extended
	pool_pkg::sum_atom_t sum_nxt;
	pool_pkg::sum_atom_t sum_shr;  // Completed sums divided by window size
	pool_pkg::atom_t     res_q;

	always_comb begin
		for (int k = 0; k < `BURST_LEN; k++) begin
			if (i_first)
				sum_nxt[k] = pool_pkg::acc_t'(i_atom[k]); // Restart on new window
			else
				sum_nxt[k] = sum_q[k] + pool_pkg::acc_t'(i_atom[k]);
			// Arithmetic shift gives floor for negative sums
			sum_shr[k] = sum_nxt[k] >>> i_window_log2;
		end
	end

	always_ff @(posedge clk) begin
		if (i_en)
			sum_q <= sum_nxt;
	end

	// Low DATA_W bits of the average
	always_ff @(posedge clk) begin
		if (i_en && i_last) begin
			for (int k = 0; k < `BURST_LEN; k++)
				res_q[k] <= pool_pkg::data_t'(sum_shr[k]);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_en && i_last; // Same cycle res_q updates
	end

	assign o_result = res_q;

endmodule

/* verilog/atom_writeback.sv */
`include "pool_defines.svh"

module atom_writeback (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_max_valid,
	input  pool_pkg::atom_t i_max_result,
	input  logic            i_ave_valid,
	input  pool_pkg::atom_t i_ave_result,
	output logic            o_wr_en,
	output pool_pkg::data_t o_wr_data,
	output logic            o_done
);

	pool_pkg::atom_t         wr_buf;    // Latched result atom
	logic [`BURST_CNT_W-1:0] word_cnt;  // Lane being written
	logic                    start;
	logic                    last_word;

	// Only one reducer is active in a run
	assign start     = i_max_valid || i_ave_valid;
	assign last_word = o_wr_en && (word_cnt == (`BURST_LEN - 1));

	always_ff @(posedge clk) begin
		if (i_max_valid)
			wr_buf <= i_max_result;
		else if (i_ave_valid)
			wr_buf <= i_ave_result;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_wr_en  <= 1'b0;
			word_cnt <= '0;
		end else if (start) begin
			// New result may land on the last word of the previous one
			o_wr_en  <= 1'b1;
			word_cnt <= '0;
		end else if (last_word) begin
			o_wr_en  <= 1'b0;
			word_cnt <= '0;
		end else if (o_wr_en) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// Lane 0 goes out first
	assign o_wr_data = wr_buf[word_cnt];
	assign o_done    = last_word;

endmodule

/* verilog/pool_engine.sv */
`include "pool_defines.svh"

module pool_engine (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_engine_valid,
	input  pool_pkg::op_e          i_op_type,
	input  logic [`WIN_LOG2_W-1:0] i_window_log2,
	input  logic [`SIDE_W-1:0]     i_o_side,
	input  pool_pkg::data_t        i_dma_rd_data,
	input  logic                   i_dma_rd_we,
	output logic                   o_dma_rd_en,
	output logic                   o_dma_wr_en,
	output pool_pkg::data_t        o_dma_wr_data,
	output logic                   o_engine_ready
);

	logic            atom_valid;   // Full atom strobe
	pool_pkg::atom_t atom;
	logic            max_en;       // Atom steered to max lanes
	logic            ave_en;       // Atom steered to sum lanes
	logic            win_first;
	logic            win_last;
	logic            max_valid;
	pool_pkg::atom_t max_result;
	logic            ave_valid;
	pool_pkg::atom_t ave_result;
	logic            wb_done;      // Last word of a result written

	pool_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.i_engine_valid (i_engine_valid),
		.i_op_type      (i_op_type),
		.i_window_log2  (i_window_log2),
		.i_o_side       (i_o_side),
		.i_atom_valid   (atom_valid),
		.i_wb_done      (wb_done),
		.o_dma_rd_en    (o_dma_rd_en),
		.o_max_en       (max_en),
		.o_ave_en       (ave_en),
		.o_win_first    (win_first),
		.o_win_last     (win_last),
		.o_engine_ready (o_engine_ready)
	);

	// Serial DMA words into parallel atoms
	atom_deserializer u_deser (
		.clk          (clk),
		.rst          (rst),
		.i_rd_en      (o_dma_rd_en),
		.i_rd_we      (i_dma_rd_we),
		.i_rd_data    (i_dma_rd_data),
		.o_atom_valid (atom_valid),
		.o_atom       (atom)
	);

	max_pool_lanes u_max (
		.clk            (clk),
		.rst            (rst),
		.i_en           (max_en),
		.i_first        (win_first),
		.i_last         (win_last),
		.i_atom         (atom),
		.o_result_valid (max_valid),
		.o_result       (max_result)
	);

	ave_pool_lanes u_ave (
		.clk            (clk),
		.rst            (rst),
		.i_en           (ave_en),
		.i_first        (win_first),
		.i_last         (win_last),
		.i_window_log2  (i_window_log2),
		.i_atom         (atom),
		.o_result_valid (ave_valid),
		.o_result       (ave_result)
	);

	// Result atom back out one word per cycle
	atom_writeback u_wb (
		.clk          (clk),
		.rst          (rst),
		.i_max_valid  (max_valid),
		.i_max_result (max_result),
		.i_ave_valid  (ave_valid),
		.i_ave_result (ave_result),
		.o_wr_en      (o_dma_wr_en),
		.o_wr_data    (o_dma_wr_data),
		.o_done       (wb_done)
	);

endmodule

/* verif/tb_pool_engine.sv */
`include "pool_defines.svh"

module tb_pool_engine;

	localparam int MAX_WIN    = 16;    // Largest window, 2^4 atoms
	localparam int WAIT_LIMIT = 5000;  // Cycles allowed for any wait

	logic                   clk;
	logic                   rst;
	logic                   i_engine_valid;
	pool_pkg::op_e          i_op_type;
	logic [`WIN_LOG2_W-1:0] i_window_log2;
	logic [`SIDE_W-1:0]     i_o_side;
	pool_pkg::data_t        i_dma_rd_data;
	logic                   i_dma_rd_we;
	logic                   o_dma_rd_en;
	logic                   o_dma_wr_en;
	pool_pkg::data_t        o_dma_wr_data;
	logic                   o_engine_ready;

	pool_pkg::data_t exp_q [$];  // Expected write words, in order
	pool_pkg::data_t exp_word;
	string           cur_test;
	int              errors;
	int              tests_run;
	int              tests_failed;
	int              wr_words;     // All write words seen
	int              burst_run;    // Length of current write burst
	bit              timed_out;

	pool_engine DUT (
		.clk            (clk),
		.rst            (rst),
		.i_engine_valid (i_engine_valid),
		.i_op_type      (i_op_type),
		.i_window_log2  (i_window_log2),
		.i_o_side       (i_o_side),
		.i_dma_rd_data  (i_dma_rd_data),
		.i_dma_rd_we    (i_dma_rd_we),
		.o_dma_rd_en    (o_dma_rd_en),
		.o_dma_wr_en    (o_dma_wr_en),
		.o_dma_wr_data  (o_dma_wr_data),
		.o_engine_ready (o_engine_ready)
	);

	always #50 clk = ~clk;

	// Expected value of one lane over the first 2^log2 atoms of a window
	function automatic pool_pkg::data_t pool_ref(input pool_pkg::op_e op, input int log2,
			input pool_pkg::data_t vals [MAX_WIN]);
		int              n;
		int              acc;   // Wide enough for 16 atoms
		pool_pkg::data_t best;
		n    = 1 << log2;
		acc  = 0;
		best = vals[0];
		for (int a = 0; a < n; a++) begin
			if (vals[a] > best)
				best = vals[a]; // Signed compare
			acc += vals[a];
		end
		if (op == pool_pkg::OP_MAXPOOL)
			return best;
		return pool_pkg::data_t'(acc >>> log2); // Floor, low 16 bits
	endfunction

	// Output monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (o_dma_wr_en) begin
			burst_run++;
			wr_words++;
			assert (exp_q.size() != 0) else begin
				$display("ERROR %s: write word seen with nothing expected", cur_test);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				assert (o_dma_wr_data === exp_word) else begin
					$display("FAIL %s: write word %0d expected %0d actual %0d",
						cur_test, wr_words - 1, exp_word, o_dma_wr_data);
					errors++;
				end
			end
		end else if (burst_run != 0) begin
			assert (burst_run == `BURST_LEN) else begin // Burst just ended
				$display("FAIL %s: write burst length expected %0d actual %0d",
					cur_test, `BURST_LEN, burst_run);
				errors++;
			end
			burst_run = 0;
		end
	end

	task automatic check_outputs_low(input string when);
		assert (!o_dma_rd_en && !o_dma_wr_en && !o_engine_ready) else begin
			$display("FAIL %s: rd_en wr_en ready %s expected 000 actual %b%b%b",
				cur_test, when, o_dma_rd_en, o_dma_wr_en, o_engine_ready);
			errors++;
		end
	endtask

	task automatic wait_rd_en(output bit ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			ok = o_dma_rd_en;
			cycles++;
		end
		if (!ok) begin
			$display("ERROR %s: the engine never started reading", cur_test);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_ready(input logic level, output bit ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			ok = (o_engine_ready == level);
			cycles++;
		end
		if (!ok) begin
			$display("ERROR %s: o_engine_ready did not go to %b in time", cur_test, level);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// One read strobe after an optional idle gap
	task automatic send_word(input pool_pkg::data_t d, input int gap);
		repeat (gap) begin
			@(posedge clk);
			i_dma_rd_we <= 1'b0;
		end
		@(posedge clk);
		i_dma_rd_we   <= 1'b1;
		i_dma_rd_data <= d;
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic run_test(input string name, input pool_pkg::op_e op, input int log2,
			input int nwin, input bit gaps);
		pool_pkg::data_t words [MAX_WIN][`BURST_LEN];
		pool_pkg::data_t lane_vals [MAX_WIN];
		int              natoms;
		int              err0;
		int              words0;
		bit              ok;
		cur_test = name;
		err0     = errors;
		words0   = wr_words;
		natoms   = 1 << log2;
		@(posedge clk);
		i_op_type      <= op;
		i_window_log2  <= `WIN_LOG2_W'(log2);
		i_o_side       <= `SIDE_W'(nwin);
		i_engine_valid <= 1'b1;
		wait_rd_en(ok);
		if (ok) begin
			for (int w = 0; w < nwin; w++) begin
				for (int a = 0; a < natoms; a++)
					for (int l = 0; l < `BURST_LEN; l++)
						words[a][l] = pool_pkg::data_t'($urandom); // Full signed range
				for (int l = 0; l < `BURST_LEN; l++) begin
					for (int a = 0; a < MAX_WIN; a++)
						lane_vals[a] = (a < natoms) ? words[a][l] : '0;
					exp_q.push_back(pool_ref(op, log2, lane_vals));
				end
				for (int a = 0; a < natoms; a++)
					for (int l = 0; l < `BURST_LEN; l++)
						send_word(words[a][l], gaps ? $urandom_range(0, 3) : 0);
			end
			@(posedge clk);
			i_dma_rd_we <= 1'b0;
			wait_ready(1'b1, ok);
		end
		if (ok) begin
			@(posedge clk);
			i_engine_valid <= 1'b0; // Back to idle
			wait_ready(1'b0, ok);
		end
		if (ok) begin
			check_outputs_low("after run");
			assert (wr_words - words0 == nwin * `BURST_LEN) else begin
				$display("FAIL %s: write word count expected %0d actual %0d",
					name, nwin * `BURST_LEN, wr_words - words0);
				errors++;
			end
			assert (exp_q.size() == 0) else begin
				$display("ERROR %s: %0d expected words never written", name, exp_q.size());
				errors++;
			end
		end
		exp_q.delete();
		report_test(name, err0);
	endtask

	initial begin
		int err0;
		void'($urandom(72269));
		clk            = 1'b0;
		rst            = 1'b1;
		i_engine_valid = 1'b0;
		i_op_type      = pool_pkg::OP_NONE;
		i_window_log2  = '0;
		i_o_side       = '0;
		i_dma_rd_data  = '0;
		i_dma_rd_we    = 1'b0;
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		wr_words       = 0;
		burst_run      = 0;
		timed_out      = 1'b0;

		cur_test = "reset";
		err0     = errors;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_outputs_low("in reset"); // Held low by async reset
		end
		@(posedge clk);
		rst <= 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_outputs_low("after reset");
		end
		report_test("reset", err0);

		run_test("max_win4", pool_pkg::OP_MAXPOOL, 2, 1, 1'b0);
		if (!timed_out)
			run_test("ave_win8", pool_pkg::OP_AVEPOOL, 3, 1, 1'b0);
		if (!timed_out)
			run_test("ave_win1", pool_pkg::OP_AVEPOOL, 0, 1, 1'b0);
		if (!timed_out)
			run_test("three_windows", pool_pkg::OP_AVEPOOL, 1, 3, 1'b1);
		if (!timed_out)
			run_test("second_run_max", pool_pkg::OP_MAXPOOL, 1, 1, 1'b1); // Other op after ave
		if (!timed_out)
			run_test("second_run_ave", pool_pkg::OP_AVEPOOL, 4, 1, 1'b1);

		$display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+common
common/pool_pkg.sv
verilog/pool_ctrl.sv
verilog/atom_deserializer.sv
pool_lanes/max_pool_lanes.sv
pool_lanes/ave_pool_lanes.sv
verilog/atom_writeback.sv
verilog/pool_engine.sv
verif/tb_pool_engine.sv
